// File: include/core_common.svh
`ifndef CORE_COMMON_SVH
`define CORE_COMMON_SVH

// Top bit indices for port ranges
`define XL          (core_pkg::XLEN - 1)
`define REG_ADDR_R  (core_pkg::REG_ADDR_W - 1)

// Memory bus ranges, one strobe per byte
`define MEM_DATA_R  (core_pkg::XLEN - 1)
`define MEM_STRB_R  ((core_pkg::XLEN / 8) - 1)

`endif

// File: design/core_pkg.sv
package core_pkg;

    // Widths
    // -------------------------------------------------
    localparam int XLEN       = 32;     // Data path width
    localparam int REG_ADDR_W = 5;      // GPR index width

    // Operation encodings
    // -------------------------------------------------
    typedef enum logic [1:0] {
        WB_OP_NONE  = 2'd0,             // No GPR write
        WB_OP_WDATA = 2'd1,             // ALU result
        WB_OP_LSU   = 2'd2,             // Formatted load data
        WB_OP_CSR   = 2'd3              // CSR old value
    } wb_op_t;

    typedef enum logic [3:0] {
        LSU_OP_NONE = 4'd0,
        LSU_OP_LB   = 4'd1,
        LSU_OP_LH   = 4'd2,
        LSU_OP_LW   = 4'd3,
        LSU_OP_LBU  = 4'd4,
        LSU_OP_LHU  = 4'd5,
        LSU_OP_SB   = 4'd6,             // Stores from here up
        LSU_OP_SH   = 4'd7,
        LSU_OP_SW   = 4'd8
    } lsu_op_t;

    // Five kinds need a third bit
    typedef enum logic [2:0] {
        CSR_OP_NONE = 3'd0,
        CSR_OP_RD   = 3'd1,             // Read only
        CSR_OP_WR   = 3'd2,             // Replace
        CSR_OP_SET  = 3'd3,             // OR in
        CSR_OP_CLR  = 3'd4              // Clear bits
    } csr_op_t;

    typedef enum logic {
        CFU_OP_NONE = 1'b0,
        CFU_OP_MRET = 1'b1              // Return to mepc
    } cfu_op_t;

    typedef enum logic [1:0] {
        WB_RUN      = 2'd0,             // Accepting work
        WB_MEM_WAIT = 2'd1,             // Waiting on dmem_gnt
        WB_CF_WAIT  = 2'd2              // Holding a control flow change
    } wb_state_t;

    // Machine CSR addresses
    // -------------------------------------------------
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // Trap causes and reset values
    // -------------------------------------------------
    localparam logic [31:0] CAUSE_ILLEGAL     = 32'd2;  // Also used for CSR errors
    localparam logic [31:0] CAUSE_LOAD_FAULT  = 32'd5;
    localparam logic [31:0] CAUSE_STORE_FAULT = 32'd7;
    localparam logic [31:0] MTVEC_RESET       = 32'h0000_0100;

endpackage

// File: design/core_lsu_rdata.sv
`timescale 1ns/1ps
`include "core_common.svh"

module core_lsu_rdata (
    input  core_pkg::lsu_op_t      lsu_op,
    input  logic [1:0]             addr_lo,        // Byte offset in the word
    input  logic [`MEM_DATA_R:0]   dmem_rdata,
    output logic [`XL:0]           lsu_rdata
);

    logic [`XL:0]   shifted;                        // Addressed byte moved to bit 0

    // Byte lane select
    // -------------------------------------------------
    assign shifted = dmem_rdata >> {addr_lo, 3'b000};

    // Extension by load kind
    always_comb begin
        case (lsu_op)
            core_pkg::LSU_OP_LB:  lsu_rdata = {{24{shifted[7]}}, shifted[7:0]};
            core_pkg::LSU_OP_LH:  lsu_rdata = {{16{shifted[15]}}, shifted[15:0]};
            core_pkg::LSU_OP_LBU: lsu_rdata = {24'd0, shifted[7:0]};
            core_pkg::LSU_OP_LHU: lsu_rdata = {16'd0, shifted[15:0]};
            core_pkg::LSU_OP_LW:  lsu_rdata = dmem_rdata;       // Whole word
            default:              lsu_rdata = '0;               // Stores and none
        endcase
    end

endmodule

// File: design/core_csrs.sv
`timescale 1ns/1ps
`include "core_common.svh"

module core_csrs (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                csr_en,
    input  core_pkg::csr_op_t   csr_op,
    input  logic [11:0]         csr_addr,
    input  logic [`XL:0]        csr_wdata,
    output logic [`XL:0]        csr_rdata,      // Old value, same cycle
    output logic                csr_error,
    input  logic                trap_en,
    input  logic [`XL:0]        trap_pc,
    input  logic [`XL:0]        trap_cause,
    input  logic                mret_en,
    output logic [`XL:0]        mtvec,
    output logic [`XL:0]        mepc
);

    logic [`XL:0]   mscratch, mcause;
    logic [`XL:0]   wr_val;
    logic           addr_ok, sw_wr;

    // Read side
    // -------------------------------------------------
    always_comb begin
        addr_ok = 1'b1;
        case (csr_addr)
            core_pkg::CSR_MTVEC:    csr_rdata = mtvec;
            core_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            core_pkg::CSR_MEPC:     csr_rdata = mepc;
            core_pkg::CSR_MCAUSE:   csr_rdata = mcause;
            default: begin
                csr_rdata = '0;
                addr_ok   = 1'b0;           // Not implemented here
            end
        endcase
    end

    assign csr_error = csr_en && !addr_ok;

    // New value for a software write
    always_comb begin
        case (csr_op)
            core_pkg::CSR_OP_WR:  wr_val = csr_wdata;
            core_pkg::CSR_OP_SET: wr_val = csr_rdata | csr_wdata;
            core_pkg::CSR_OP_CLR: wr_val = csr_rdata & ~csr_wdata;
            default:              wr_val = csr_rdata;
        endcase
    end

    // No software write alongside a control flow commit
    assign sw_wr = csr_en && addr_ok && csr_op != core_pkg::CSR_OP_RD &&
                   !trap_en && !mret_en;

    // Register updates
    // -------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= core_pkg::MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap_en) begin
            mepc   <= {trap_pc[`XL:2], 2'b00};  // Trap capture wins
            mcause <= trap_cause;
        end else if (sw_wr) begin
            case (csr_addr)
                core_pkg::CSR_MTVEC:    mtvec    <= {wr_val[`XL:2], 2'b00};
                core_pkg::CSR_MSCRATCH: mscratch <= wr_val;
                core_pkg::CSR_MEPC:     mepc     <= {wr_val[`XL:2], 2'b00};
                core_pkg::CSR_MCAUSE:   mcause   <= wr_val;
                default:                mscratch <= mscratch;
            endcase
        end
    end

endmodule

// File: design/core_regfile.sv
`timescale 1ns/1ps
`include "core_common.svh"

module core_regfile (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   rd_wen,
    input  logic [`REG_ADDR_R:0]   rd_addr,
    input  logic [`XL:0]           rd_wdata,
    input  logic [`REG_ADDR_R:0]   rs1_addr,
    input  logic [`REG_ADDR_R:0]   rs2_addr,
    output logic [`XL:0]           rs1_data,
    output logic [`XL:0]           rs2_data
);

    logic [`XL:0] regs [32];            // x0 slot stays zero

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata;  // x0 writes dropped
        end
    end

    // Old value shows during a same-cycle write
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// File: design/core_pipe_wb.sv
`timescale 1ns/1ps
`include "core_common.svh"

module core_pipe_wb (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   s3_full,        // Instruction present
    output logic                   s3_ready,       // Retire strobe with s3_full
    input  logic [`XL:0]           s3_pc,
    input  logic [31:0]            s3_instr,
    input  logic [`XL:0]           s3_wdata,       // ALU result or CSR operand
    input  logic [`REG_ADDR_R:0]   s3_rd,
    input  core_pkg::lsu_op_t      s3_lsu_op,
    input  core_pkg::csr_op_t      s3_csr_op,
    input  logic [11:0]            s3_csr_addr,
    input  core_pkg::cfu_op_t      s3_cfu_op,
    input  core_pkg::wb_op_t       s3_wb_op,
    input  logic                   s3_trap,        // Illegal flagged upstream
    input  logic                   dmem_gnt,
    input  logic                   dmem_err,
    input  logic [`XL:0]           lsu_rdata,      // Already aligned and extended
    output logic                   s3_cf_valid,
    input  logic                   s3_cf_ack,
    output logic [`XL:0]           s3_cf_target,
    output logic                   csr_en,
    output core_pkg::csr_op_t      csr_op,
    output logic [11:0]            csr_addr,
    output logic [`XL:0]           csr_wdata,
    input  logic [`XL:0]           csr_rdata,
    input  logic                   csr_error,
    input  logic [`XL:0]           mtvec,
    input  logic [`XL:0]           mepc,
    output logic                   trap_en,
    output logic [`XL:0]           trap_pc,
    output logic [`XL:0]           trap_cause,
    output logic                   mret_en,
    output logic                   rd_wen,
    output logic [`REG_ADDR_R:0]   rd_addr,
    output logic [`XL:0]           rd_wdata
);

    core_pkg::wb_state_t state, state_nx;

    logic           in_run, is_mem, is_store, is_mret, csr_ro, csr_fault;
    logic           mem_done, mem_ret, plain_ret, cf_done;
    logic           raise_trap, raise_mret;
    logic [`XL:0]   cause_nx;
    logic           cf_trap_q;                      // Pending change is a trap
    logic [`XL:0]   cf_cause_q, cf_target_q;

    // Instruction classification
    // -------------------------------------------------
    assign in_run   = state == core_pkg::WB_RUN;
    assign is_mem   = s3_lsu_op != core_pkg::LSU_OP_NONE;
    assign is_store = s3_lsu_op inside {core_pkg::LSU_OP_SB, core_pkg::LSU_OP_SH,
                                        core_pkg::LSU_OP_SW};
    assign is_mret  = s3_cfu_op == core_pkg::CFU_OP_MRET;
    assign csr_ro   = s3_instr[19:15] == 5'd0;      // rs1/uimm field is zero

    // CSR access, first cycle only
    // -------------------------------------------------
    assign csr_en    = s3_full && in_run && !s3_trap && s3_csr_op != core_pkg::CSR_OP_NONE;
    assign csr_addr  = s3_csr_addr;
    assign csr_wdata = s3_wdata;
    assign csr_fault = csr_en && csr_error;

    // Set or clear with a zero rs1 field only reads
    always_comb begin
        csr_op = s3_csr_op;
        if (csr_ro && (s3_csr_op == core_pkg::CSR_OP_SET ||
                       s3_csr_op == core_pkg::CSR_OP_CLR)) begin
            csr_op = core_pkg::CSR_OP_RD;
        end
    end

    // Retire and control flow conditions
    // -------------------------------------------------
    assign mem_done   = s3_full && is_mem && !s3_trap && !s3_cf_valid && dmem_gnt;
    assign mem_ret    = mem_done && !dmem_err;
    assign plain_ret  = s3_full && in_run && !s3_trap && !csr_fault && !is_mret && !is_mem;
    assign raise_trap = (s3_full && in_run && (s3_trap || csr_fault)) || (mem_done && dmem_err);
    assign raise_mret = s3_full && in_run && !s3_trap && !csr_fault && is_mret;
    assign cf_done    = s3_cf_valid && s3_cf_ack;   // Fetch took the change

    assign s3_ready = !s3_full || plain_ret || mem_ret || cf_done;

    always_comb begin
        if (s3_trap || csr_fault) begin
            cause_nx = core_pkg::CAUSE_ILLEGAL;
        end else if (is_store) begin
            cause_nx = core_pkg::CAUSE_STORE_FAULT;
        end else begin
            cause_nx = core_pkg::CAUSE_LOAD_FAULT;
        end
    end

    // Stage FSM
    // -------------------------------------------------
    always_comb begin
        state_nx = state;
        case (state)
            core_pkg::WB_RUN: begin
                if (raise_trap || raise_mret) begin
                    state_nx = core_pkg::WB_CF_WAIT;
                end else if (s3_full && is_mem && !dmem_gnt) begin
                    state_nx = core_pkg::WB_MEM_WAIT;   // Response not yet back
                end
            end
            core_pkg::WB_MEM_WAIT: begin
                if (raise_trap) begin
                    state_nx = core_pkg::WB_CF_WAIT;
                end else if (mem_ret) begin
                    state_nx = core_pkg::WB_RUN;
                end
            end
            core_pkg::WB_CF_WAIT: begin
                if (s3_cf_ack) begin
                    state_nx = core_pkg::WB_RUN;
                end
            end
            default: state_nx = core_pkg::WB_RUN;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state     <= core_pkg::WB_RUN;
            cf_trap_q <= 1'b0;
        end else begin
            state <= state_nx;
            if (raise_trap || raise_mret) begin
                cf_trap_q <= raise_trap;
            end
        end
    end

    // Cause and target frozen on entry to CF_WAIT
    always_ff @(posedge g_clk) begin
        if (raise_trap || raise_mret) begin
            cf_cause_q  <= cause_nx;
            cf_target_q <= raise_trap ? mtvec : mepc;
        end
    end

    assign s3_cf_valid  = state == core_pkg::WB_CF_WAIT;  // Level until ack
    assign s3_cf_target = cf_target_q;

    // Trap capture and MRET at the acknowledge
    assign trap_en    = cf_done && cf_trap_q;
    assign mret_en    = cf_done && !cf_trap_q;
    assign trap_pc    = s3_pc;                      // Held until retire
    assign trap_cause = cf_cause_q;

    // GPR writeback
    // -------------------------------------------------
    assign rd_wen  = (plain_ret || mem_ret) && s3_wb_op != core_pkg::WB_OP_NONE;
    assign rd_addr = s3_rd;

    always_comb begin
        case (s3_wb_op)
            core_pkg::WB_OP_WDATA: rd_wdata = s3_wdata;
            core_pkg::WB_OP_LSU:   rd_wdata = lsu_rdata;
            core_pkg::WB_OP_CSR:   rd_wdata = csr_rdata;    // Old CSR value
            default:               rd_wdata = '0;
        endcase
    end

endmodule

// File: design/core_wb_top.sv
`timescale 1ns/1ps
`include "core_common.svh"

module core_wb_top (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   s3_full,
    output logic                   s3_ready,
    input  logic [`XL:0]           s3_pc,
    input  logic [31:0]            s3_instr,
    input  logic [`XL:0]           s3_wdata,
    input  logic [`REG_ADDR_R:0]   s3_rd,
    input  core_pkg::lsu_op_t      s3_lsu_op,
    input  core_pkg::csr_op_t      s3_csr_op,
    input  logic [11:0]            s3_csr_addr,
    input  core_pkg::cfu_op_t      s3_cfu_op,
    input  core_pkg::wb_op_t       s3_wb_op,
    input  logic                   s3_trap,
    input  logic [`XL:0]           dmem_addr,
    input  logic                   dmem_gnt,
    input  logic                   dmem_err,
    input  logic [`MEM_DATA_R:0]   dmem_rdata,
    output logic                   s3_cf_valid,
    input  logic                   s3_cf_ack,
    output logic [`XL:0]           s3_cf_target,
    output logic                   rd_wen,
    output logic [`REG_ADDR_R:0]   rd_addr,
    output logic [`XL:0]           rd_wdata,
    input  logic [`REG_ADDR_R:0]   rs1_addr,
    input  logic [`REG_ADDR_R:0]   rs2_addr,
    output logic [`XL:0]           rs1_data,
    output logic [`XL:0]           rs2_data
);

    logic [`XL:0]       lsu_rdata;
    logic               csr_en, csr_error, trap_en, mret_en;
    core_pkg::csr_op_t  csr_op;
    logic [11:0]        csr_addr;
    logic [`XL:0]       csr_wdata, csr_rdata, trap_pc, trap_cause, mtvec, mepc;

    core_pipe_wb i_pipe_wb (.*);        // Stage FSM and writeback select

    core_lsu_rdata i_lsu_rdata (
        .lsu_op     (s3_lsu_op),
        .addr_lo    (dmem_addr[1:0]),   // Only the byte offset matters here
        .dmem_rdata (dmem_rdata),
        .lsu_rdata  (lsu_rdata)
    );

    core_csrs i_csrs (.*);              // mtvec, mscratch, mepc, mcause

    core_regfile i_regfile (.*);

endmodule

// File: bench/core_wb_chk.sv
`timescale 1ns/1ps

module core_wb_chk (
    input logic g_clk,
    input logic g_resetn,
    input logic s3_ready,
    input logic s3_cf_valid,
    input logic s3_cf_ack,
    input logic rd_wen
);

    int fail_count = 0;                 // Failed assertion count

    // Control flow level holds until fetch takes it
    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_cf_valid && !s3_cf_ack |=> s3_cf_valid)
        else begin
            fail_count++;
            $error("s3_cf_valid dropped before s3_cf_ack");
        end

    a_no_wr_in_cf: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(rd_wen && s3_cf_valid))
        else begin
            fail_count++;
            $error("rd_wen high while s3_cf_valid is high");   // Trapping work never writes
        end

    // Stage stalls until the acknowledge
    a_stall_in_cf: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_cf_valid && !s3_cf_ack |-> !s3_ready)
        else begin
            fail_count++;
            $error("s3_ready high while a control flow change is pending");
        end

endmodule

bind core_wb_top core_wb_chk i_wb_chk (.*);

// File: bench/core_wb_check.sv
`timescale 1ns/1ps

module core_wb_check #(
    parameter int NREC = 21,
    parameter int NW   = 17
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        s3_full,
    input  logic        s3_ready,
    input  logic        s3_cf_valid,
    input  logic        s3_cf_ack,
    input  logic [31:0] s3_cf_target,
    input  logic        rd_wen,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_wdata,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output int          err_count,
    output int          retire_count
);

    logic [31:0] rec [NREC*NW];         // Same layout as the driver
    logic [31:0] gpr [32];              // Model GPRs
    logic [31:0] csr_m [4];             // mtvec, mscratch, mepc, mcause
    int          idx, base;
    logic        is_cf, exp_wr, cf_done;

    initial begin
        $readmemh("bench/core_wb_tests.txt", rec);
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        csr_m[0] = core_pkg::MTVEC_RESET;
        csr_m[1] = '0;
        csr_m[2] = '0;
        csr_m[3] = '0;
        err_count    = 0;
        retire_count = 0;
        idx          = 0;
    end

    function automatic int csr_index(input logic [11:0] a);
        case (a)
            core_pkg::CSR_MTVEC:    return 0;
            core_pkg::CSR_MSCRATCH: return 1;
            core_pkg::CSR_MEPC:     return 2;
            core_pkg::CSR_MCAUSE:   return 3;
            default:                return -1;      // Unknown, traps
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        err_count++;
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    task automatic report_fault(input string what);
        err_count++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // Control flow change taken by fetch
    // -------------------------------------------------
    task automatic check_cf(input int b);
        logic [31:0] model_tgt;
        logic [31:0] cause;
        model_tgt = (rec[b+7][0]) ? csr_m[2] : csr_m[0];    // MRET or trap
        if (s3_cf_target !== rec[b+16]) report_mismatch("s3_cf_target", rec[b+16], s3_cf_target);
        if (s3_cf_target !== model_tgt) report_mismatch("s3_cf_target (model)", model_tgt,
                                                        s3_cf_target);
        if (!rec[b+7][0]) begin
            if (rec[b+9][0] || rec[b+5][2:0] != 3'd0) cause = core_pkg::CAUSE_ILLEGAL;
            else if (rec[b+4][3:0] >= 4'd6) cause = core_pkg::CAUSE_STORE_FAULT;
            else cause = core_pkg::CAUSE_LOAD_FAULT;
            csr_m[2] = {rec[b][31:2], 2'b00};   // Trap capture
            csr_m[3] = cause;
        end
    endtask

    task automatic update_csr_model(input int b);
        int          ci;
        logic [31:0] old_v;
        logic [31:0] new_v;
        ci = csr_index(rec[b+6][11:0]);
        if (rec[b+5][2:0] != 3'd0 && ci >= 0) begin
            old_v = csr_m[ci];
            if (rd_wen && rec[b+8][1:0] == 2'd3 && rd_wdata !== old_v) begin
                report_mismatch("rd_wdata (model)", old_v, rd_wdata);   // Old CSR value
            end
            case (core_pkg::csr_op_t'(rec[b+5][2:0]))
                core_pkg::CSR_OP_WR:  new_v = rec[b+2];
                core_pkg::CSR_OP_SET: new_v = old_v | rec[b+2];
                core_pkg::CSR_OP_CLR: new_v = old_v & ~rec[b+2];
                default:              new_v = old_v;
            endcase
            if (ci == 0 || ci == 2) new_v[1:0] = 2'b00;     // Aligned targets
            csr_m[ci] = new_v;
        end
    endtask

    // Per-cycle compare
    // -------------------------------------------------
    always @(posedge g_clk) begin
        if (g_resetn) begin
            if (rs1_data !== gpr[rs1_addr]) report_mismatch("rs1_data", gpr[rs1_addr], rs1_data);
            if (rs2_data !== gpr[rs2_addr]) report_mismatch("rs2_data", gpr[rs2_addr], rs2_data);
            if (idx < NREC) begin
                base    = idx * NW;
                is_cf   = rec[base+16] != '0;
                exp_wr  = !is_cf && rec[base+8][1:0] != 2'd0;
                cf_done = s3_cf_valid && s3_cf_ack;
                if (cf_done) check_cf(base);
                if (s3_full && s3_ready) begin
                    if (is_cf && !cf_done) report_fault("retired without a control flow change");
                    if (exp_wr && !rd_wen) report_fault("expected GPR write missing at retire");
                    if (!exp_wr && rd_wen) report_fault("GPR write from a non-writing instruction");
                    if (rd_wen) begin
                        if (rd_addr !== rec[base+3][4:0]) report_mismatch("rd_addr",
                            {27'd0, rec[base+3][4:0]}, {27'd0, rd_addr});
                        if (rd_wdata !== rec[base+15]) report_mismatch("rd_wdata",
                            rec[base+15], rd_wdata);
                    end
                    if (exp_wr && rec[base+3][4:0] != 5'd0) gpr[rec[base+3][4:0]] = rec[base+15];
                    if (!is_cf) update_csr_model(base);
                    retire_count++;
                    idx++;
                end else if (rd_wen) begin
                    report_fault("GPR write without a retire");
                end
            end else if (rd_wen || s3_cf_valid) begin
                report_fault("DUT activity after the last instruction");
            end
        end
    end

endmodule

// File: bench/core_wb_tb.sv
`timescale 1ns/1ps

module core_wb_tb;

    localparam int NREC = 21;           // Lines in the test file
    localparam int NW   = 17;           // Words per line

    logic                g_clk, g_resetn;
    logic                s3_full, s3_ready, s3_trap;
    logic [31:0]         s3_pc, s3_instr, s3_wdata;
    logic [4:0]          s3_rd, rd_addr, rs1_addr, rs2_addr;
    core_pkg::lsu_op_t   s3_lsu_op;
    core_pkg::csr_op_t   s3_csr_op;
    logic [11:0]         s3_csr_addr;
    core_pkg::cfu_op_t   s3_cfu_op;
    core_pkg::wb_op_t    s3_wb_op;
    logic [31:0]         dmem_addr, dmem_rdata, s3_cf_target, rd_wdata, rs1_data, rs2_data;
    logic                dmem_gnt, dmem_err, s3_cf_valid, s3_cf_ack, rd_wen;
    logic [31:0]         rec [NREC*NW];
    logic [31:0]         lcg_state;
    int                  err_count, retire_count, cycles, limit, max_dly, total_err;

    core_wb_top i_dut (.*);

    core_wb_check #(.NREC(NREC), .NW(NW)) i_check (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;    // 20 ns period
    end

    // Run limit
    always @(posedge g_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // One instruction, driven on falling edges until it retires
    // -------------------------------------------------
    task automatic run_record(input int i);
        int   b, n, acks;
        logic done;
        b = i * NW;
        s3_full     = 1'b1;
        s3_pc       = rec[b];
        s3_instr    = rec[b+1];
        s3_wdata    = rec[b+2];
        s3_rd       = rec[b+3][4:0];
        s3_lsu_op   = core_pkg::lsu_op_t'(rec[b+4][3:0]);
        s3_csr_op   = core_pkg::csr_op_t'(rec[b+5][2:0]);
        s3_csr_addr = rec[b+6][11:0];
        s3_cfu_op   = core_pkg::cfu_op_t'(rec[b+7][0]);
        s3_wb_op    = core_pkg::wb_op_t'(rec[b+8][1:0]);
        s3_trap     = rec[b+9][0];
        dmem_addr   = rec[b+10];
        dmem_rdata  = rec[b+11];
        n    = 0;
        acks = 0;
        done = 1'b0;
        while (!done) begin
            dmem_gnt  = rec[b+4][3:0] != 4'd0 && n == int'(rec[b+13]);   // One-cycle response
            dmem_err  = dmem_gnt && rec[b+12][0];
            if (s3_cf_valid) acks++;
            s3_cf_ack = s3_cf_valid && acks > int'(rec[b+14]);           // Held back
            lcg_state = lcg_next(lcg_state);
            rs1_addr  = lcg_state[20:16];
            rs2_addr  = lcg_state[28:24];
            if (n == 0 && i > 0) begin
                rs1_addr = rec[b-NW+3][4:0];    // Read back the last destination
            end
            #1 done = s3_ready;
            @(negedge g_clk);
            n++;
        end
        s3_full   = 1'b0;
        dmem_gnt  = 1'b0;
        dmem_err  = 1'b0;
        s3_cf_ack = 1'b0;
    endtask

    initial begin
        $readmemh("bench/core_wb_tests.txt", rec);
        max_dly = 0;
        for (int i = 0; i < NREC; i++) begin
            if (int'(rec[i*NW+13]) > max_dly) max_dly = int'(rec[i*NW+13]);
            if (int'(rec[i*NW+14]) > max_dly) max_dly = int'(rec[i*NW+14]);
        end
        limit  = 20 + NREC * (8 + max_dly);
        cycles = 0;
        lcg_state = 32'h627c25b1;
        g_resetn = 1'b0;
        s3_full = 1'b0;
        s3_pc = '0;
        s3_instr = '0;
        s3_wdata = '0;
        s3_rd = '0;
        s3_lsu_op = core_pkg::LSU_OP_NONE;
        s3_csr_op = core_pkg::CSR_OP_NONE;
        s3_csr_addr = '0;
        s3_cfu_op = core_pkg::CFU_OP_NONE;
        s3_wb_op = core_pkg::WB_OP_NONE;
        s3_trap = 1'b0;
        dmem_addr = '0;
        dmem_gnt = 1'b0;
        dmem_err = 1'b0;
        dmem_rdata = '0;
        s3_cf_ack = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        repeat (8) @(posedge g_clk);    // Reset held 8 cycles
        @(negedge g_clk);
        g_resetn = 1'b1;
        @(negedge g_clk);
        for (int i = 0; i < NREC; i++) begin
            run_record(i);
        end
        repeat (3) @(negedge g_clk);
        total_err = err_count + i_dut.i_wb_chk.fail_count;
        if (retire_count != NREC) begin
            $display("Only %0d of %0d instructions retired", retire_count, NREC);
            total_err++;
        end
        $display("Run complete with %0d errors and %0d retires", total_err, retire_count);
        if (total_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: bench/core_wb_tests.txt
// pc instr wdata rd lsu_op csr_op csr_addr cfu_op wb_op trap dmem_addr dmem_rdata
// err gnt_dly ack_dly exp_rd exp_cf_target (exp_cf_target of zero means no control flow change)
00001000 00000013 12345678 01 0 0 000 0 1 0 00000000 00000000 0 0 0 12345678 00000000
00001004 00000013 deadbeef 00 0 0 000 0 1 0 00000000 00000000 0 1 0 deadbeef 00000000
00001008 00000003 00000000 02 1 0 000 0 2 0 00002000 8899aabb 0 0 0 ffffffbb 00000000
0000100c 00000003 00000000 03 1 0 000 0 2 0 00002001 8899aabb 0 1 0 ffffffaa 00000000
00001010 00000003 00000000 04 1 0 000 0 2 0 00002002 8899aabb 0 2 0 ffffff99 00000000
00001014 00000003 00000000 05 1 0 000 0 2 0 00002003 8899aabb 0 3 0 ffffff88 00000000
00001018 00004003 00000000 06 4 0 000 0 2 0 00002001 8899aabb 0 2 0 000000aa 00000000
0000101c 00001003 00000000 07 2 0 000 0 2 0 00002002 8899aabb 0 1 0 ffff8899 00000000
00001020 00005003 00000000 08 5 0 000 0 2 0 00002000 8899aabb 0 0 0 0000aabb 00000000
00001024 00002003 00000000 09 3 0 000 0 2 0 00002000 8899aabb 0 3 0 8899aabb 00000000
00001028 00008073 a5a5a5a5 0a 0 2 340 0 3 0 00000000 00000000 0 0 0 00000000 00000000
0000102c 00008073 0000000f 0b 0 3 340 0 3 0 00000000 00000000 0 0 0 a5a5a5a5 00000000
00001030 00008073 000000ff 0c 0 4 340 0 3 0 00000000 00000000 0 0 0 a5a5a5af 00000000
00001034 00002073 00000000 0d 0 1 340 0 3 0 00000000 00000000 0 0 0 a5a5a500 00000000
00001038 00008073 00000203 0e 0 2 305 0 3 0 00000000 00000000 0 0 0 00000100 00000000
00001040 00008073 00000000 0f 0 1 7c0 0 3 0 00000000 00000000 0 0 3 00000000 00000200
00001044 00000000 11111111 12 0 0 000 0 1 1 00000000 00000000 0 0 2 00000000 00000200
00001048 00002003 00000000 13 3 0 000 0 2 0 00003000 cafef00d 1 2 1 00000000 00000200
00001100 30200073 00000000 00 0 0 000 1 0 0 00000000 00000000 0 0 0 00000000 00001048
00001104 00002073 00000000 10 0 1 342 0 3 0 00000000 00000000 0 0 0 00000005 00000000
00001108 00002073 00000000 11 0 1 341 0 3 0 00000000 00000000 0 0 0 00001048 00000000

// File: core_wb_top.f
+incdir+include
design/core_pkg.sv
design/core_lsu_rdata.sv
design/core_csrs.sv
design/core_regfile.sv
design/core_pipe_wb.sv
design/core_wb_top.sv
bench/core_wb_chk.sv
bench/core_wb_check.sv
bench/core_wb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f core_wb_top.f --top-module core_wb_tb -o core_wb_sim
./obj_dir/core_wb_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
